/* hdl/gfx_mapper_table.svh */
// ==================================================
// Per-game bank table: primary, alternate, select
// Case items for the game case of the bank mapper
// ==================================================

// Banks are one-hot, all zero means no bank
// Effective bank is alt_bank when alt_sel is set
// code_in holds the tile code on ROM bits 15 to 6

// One bank per scroll layer and objects
GAME_SPLIT: begin
    alt_bank <= 4'b0000;  // Never selected
    alt_sel  <= 1'b0;
    case (req_in.layer)
        LAYER_OBJ:  prim_bank <= 4'b0001;
        LAYER_SCR1: prim_bank <= 4'b0010;
        LAYER_SCR2: prim_bank <= 4'b0100;
        LAYER_SCR3: prim_bank <= 4'b1000;
        default:    prim_bank <= 4'b0000;  // Stars and bad layers
    endcase
end

// Objects split over two banks by the top code bit
GAME_OBJALT: begin
    alt_bank <= 4'b0010;
    if (req_in.layer == LAYER_OBJ) begin
        prim_bank <= 4'b0001;
        alt_sel   <= code_in[15];  // Upper object half
    end else begin
        prim_bank <= 4'b0100;  // All scroll data shares one bank
        alt_sel   <= 1'b0;
    end
end

// Code bits 15 and 14 pick the bank directly
GAME_CODESEL: begin
    alt_bank <= 4'b0000;
    alt_sel  <= 1'b0;
    if (req_in.layer == LAYER_STARS) begin
        prim_bank <= 4'b0000;  // Star field has no ROM here
    end else begin
        prim_bank <= 4'b0001 << code_in[15:14];
    end
end

/* hdl/gfx_pkg.sv */
// ==================================================
// Graphics ROM mapper shared types and constants
// Layer codes, game ids, request/config/bank structs
// ==================================================
package gfx_pkg;

    // Field widths
    localparam int GAME_W    = 6;
    localparam int CODE_W    = 10;  // Tile code, ROM address bits 15 to 6
    localparam int LAYER_W   = 3;
    localparam int BANK_W    = 4;   // One-hot bank, also nibble width
    localparam int ROW_DEF_W = 4;   // Row field carried in a request

    // Layer codes, top bits of the ROM address
    localparam logic [LAYER_W-1:0] LAYER_OBJ   = 3'd0;
    localparam logic [LAYER_W-1:0] LAYER_SCR1  = 3'd1;
    localparam logic [LAYER_W-1:0] LAYER_SCR2  = 3'd2;
    localparam logic [LAYER_W-1:0] LAYER_SCR3  = 3'd3;
    localparam logic [LAYER_W-1:0] LAYER_STARS = 3'd4;

    // Game ids known to the bank mapper
    localparam logic [GAME_W-1:0] GAME_PLAIN   = 6'd0;  // Also any unknown id
    localparam logic [GAME_W-1:0] GAME_SPLIT   = 6'd1;
    localparam logic [GAME_W-1:0] GAME_OBJALT  = 6'd2;
    localparam logic [GAME_W-1:0] GAME_CODESEL = 6'd3;

    // Graphics request from a renderer
    typedef struct packed {
        logic                 valid;  // Single cycle strobe
        logic [LAYER_W-1:0]   layer;
        logic [CODE_W-1:0]    code;
        logic [ROW_DEF_W-1:0] row;
    } gfx_req_t;

    // CPU loaded configuration
    typedef struct packed {
        logic [GAME_W-1:0]   game;
        logic [4*BANK_W-1:0] bank_offset;  // Nibble k for bank k
        logic [4*BANK_W-1:0] bank_mask;
    } gfx_cfg_t;

    // Bank decode result for one request
    typedef struct packed {
        logic [BANK_W-1:0] offset;
        logic [BANK_W-1:0] mask;
        logic              unmapped;  // No bank hit
    } gfx_bank_t;

endpackage

/* hdl/gfx_map_cfg.sv */
// ==================================================
// CPU side config registers for the ROM mapper
// ==================================================
`timescale 1ns/10ps

module gfx_map_cfg (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_we,    // One cycle write strobe
    input  logic [1:0]        cfg_addr,
    input  logic [15:0]       cfg_din,
    output gfx_pkg::gfx_cfg_t cfg
);
    import gfx_pkg::*;

    // Register map
    localparam logic [1:0] ADDR_GAME   = 2'd0;
    localparam logic [1:0] ADDR_OFFSET = 2'd1;
    localparam logic [1:0] ADDR_MASK   = 2'd2;

    gfx_cfg_t cfg_q;  // Live configuration

    // Writes land on the edge after the strobe is seen
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg_q.game        <= GAME_PLAIN;
            cfg_q.bank_offset <= 16'h0000;
            cfg_q.bank_mask   <= 16'hffff;  // All code bits pass through
        end else if (cfg_we) begin
            case (cfg_addr)
                ADDR_GAME: begin
                    cfg_q.game <= cfg_din[GAME_W-1:0];  // Upper bits dropped
                end
                ADDR_OFFSET: begin
                    cfg_q.bank_offset <= cfg_din;
                end
                ADDR_MASK: begin
                    cfg_q.bank_mask <= cfg_din;
                end
                default: begin
                    // Address 3 unused, write is dropped
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    // Registers go straight out to the mapper
    assign cfg = cfg_q;

endmodule

/* hdl/gfx_bank_mapper.sv */
// ==================================================
// Two stage bank decode: game/layer/code to bank,
// then bank to offset and mask nibbles
// ==================================================
`timescale 1ns/10ps

module gfx_bank_mapper #(
    parameter int ROW_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  gfx_pkg::gfx_cfg_t  cfg,
    input  gfx_pkg::gfx_req_t  req_in,
    output gfx_pkg::gfx_bank_t bank,
    output gfx_pkg::gfx_req_t  req_out
);
    import gfx_pkg::*;

    logic [15:6]         code_in;    // Code seen as ROM address bits
    logic [BANK_W-1:0]   prim_bank;
    logic [BANK_W-1:0]   alt_bank;
    logic                alt_sel;
    logic [BANK_W-1:0]   eff_bank;
    logic [4*BANK_W-1:0] offset_q1;  // Config taken at decode time
    logic [4*BANK_W-1:0] mask_q1;
    logic                vld_q1;
    logic                vld_q2;
    logic [LAYER_W-1:0]  layer_q1;
    logic [LAYER_W-1:0]  layer_q2;
    logic [CODE_W-1:0]   code_q1;
    logic [CODE_W-1:0]   code_q2;
    logic [ROW_W-1:0]    row_q1;     // Only the used row bits travel
    logic [ROW_W-1:0]    row_q2;

    assign code_in = req_in.code;

    // Stage 1: bank choice per game
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            prim_bank <= 4'b0000;
            alt_bank  <= 4'b0000;
            alt_sel   <= 1'b0;
        end else if (req_in.valid) begin
            case (cfg.game)
                `include "gfx_mapper_table.svh"
                default: begin  // Plain layout and unknown ids
                    prim_bank <= 4'b0001;
                    alt_bank  <= 4'b0000;
                    alt_sel   <= 1'b0;
                end
            endcase
        end
    end

    assign eff_bank = alt_sel ? alt_bank : prim_bank;

    // Stage 2: nibble select from the captured config
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank <= '{offset: 4'h0, mask: 4'hf, unmapped: 1'b1};
        end else if (vld_q1) begin
            case (eff_bank)
                4'b0001: bank <= '{offset_q1[3:0], mask_q1[3:0], 1'b0};
                4'b0010: bank <= '{offset_q1[7:4], mask_q1[7:4], 1'b0};
                4'b0100: bank <= '{offset_q1[11:8], mask_q1[11:8], 1'b0};
                4'b1000: bank <= '{offset_q1[15:12], mask_q1[15:12], 1'b0};
                default: bank <= '{4'h0, 4'hf, 1'b1};  // Falls in no bank
            endcase
        end
    end

    // Valid pipe, matches the two decode stages
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vld_q1 <= 1'b0;
            vld_q2 <= 1'b0;
        end else begin
            vld_q1 <= req_in.valid;
            vld_q2 <= vld_q1;
        end
    end

    // Request payload, moves only with a valid request
    always_ff @(posedge clk) begin
        if (req_in.valid) begin
            offset_q1 <= cfg.bank_offset;
            mask_q1   <= cfg.bank_mask;
            layer_q1  <= req_in.layer;
            code_q1   <= req_in.code;
            row_q1    <= ROW_W'(req_in.row);
        end
        if (vld_q1) begin
            layer_q2 <= layer_q1;
            code_q2  <= code_q1;
            row_q2   <= row_q1;
        end
    end

    assign req_out = '{valid: vld_q2, layer: layer_q2, code: code_q2,
                       row: ROW_DEF_W'(row_q2)};

endmodule

/* hdl/gfx_rom_addr.sv */
// ==================================================
// ROM address builder: bank field merge and the
// registered address, valid and unmapped outputs
// ==================================================
`timescale 1ns/10ps

module gfx_rom_addr #(
    parameter  int ROW_W  = 4,
    localparam int ADDR_W = 3 + 4 + 6 + ROW_W  // Layer, bank, code, row
) (
    input  logic               clk,
    input  logic               rst,
    input  gfx_pkg::gfx_bank_t bank,
    input  gfx_pkg::gfx_req_t  req,
    output logic [ADDR_W-1:0]  rom_addr,
    output logic               rom_valid,
    output logic               rom_unmapped
);
    import gfx_pkg::*;

    logic [15:6]       code;        // Code on ROM bits 15 to 6
    logic [BANK_W-1:0] bank_field;  // Final ROM bits 15 to 12
    logic [ROW_W-1:0]  row;
    logic [ADDR_W-1:0] addr_next;

    assign code = req.code;

    // Mask picks which code bits survive, offset forces the rest
    assign bank_field = bank.offset | (code[15:12] & bank.mask);

    // Row resized to the configured width
    assign row = ROW_W'(req.row);

    // Address from most to least significant field
    assign addr_next = {
        req.layer,    // Layer selects the ROM region
        bank_field,
        code[11:6],   // Low code bits go straight through
        row
    };

    // Control outputs
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_valid    <= 1'b0;
            rom_unmapped <= 1'b1;  // Nothing mapped until a request
        end else begin
            rom_valid <= req.valid;
            if (req.valid) begin
                rom_unmapped <= bank.unmapped;
            end
        end
    end

    // Address held between requests
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rom_addr <= addr_next;
        end
    end

endmodule

/* hdl/cps_gfxmap_top.sv */
// ==================================================
// Graphics ROM address mapping top level
// Config block, bank mapper, address builder
// ==================================================
`timescale 1ns/10ps

module cps_gfxmap_top #(
    parameter  int ROW_W  = 4,            // Tile row bits in the address
    localparam int ADDR_W = 3 + 4 + 6 + ROW_W
) (
    input  logic              clk,
    input  logic              rst,

    // CPU config port
    input  logic              cfg_we,
    input  logic [1:0]        cfg_addr,
    input  logic [15:0]       cfg_din,

    // Request in, result out three cycles later
    input  gfx_pkg::gfx_req_t req,
    output logic [ADDR_W-1:0] rom_addr,
    output logic              rom_valid,
    output logic              rom_unmapped
);
    import gfx_pkg::*;

    gfx_cfg_t  cfg;    // Live config to the mapper
    gfx_bank_t bank;   // Offset, mask and miss flag
    gfx_req_t  req_d;  // Request aligned with bank

    // Config registers
    gfx_map_cfg u_cfg (
        .clk      (clk),
        .rst      (rst),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_din  (cfg_din),
        .cfg      (cfg)
    );

    // Two cycle bank decode
    gfx_bank_mapper #(
        .ROW_W (ROW_W)
    ) u_mapper (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .req_in  (req),
        .bank    (bank),
        .req_out (req_d)
    );

    // Final address register
    gfx_rom_addr #(
        .ROW_W (ROW_W)
    ) u_addr (
        .clk          (clk),
        .rst          (rst),
        .bank         (bank),
        .req          (req_d),
        .rom_addr     (rom_addr),
        .rom_valid    (rom_valid),
        .rom_unmapped (rom_unmapped)
    );

endmodule

/* verification/cps_gfxmap_tb.sv */
// ==================================================
// Testbench for the graphics ROM address mapper
// Clock, reset, config writes, LFSR stimulus, checker
// ==================================================
`timescale 1ns/10ps

module cps_gfxmap_tb;
    import gfx_pkg::*;

    localparam int ROW_W        = 4;
    localparam int ADDR_W       = 3 + 4 + 6 + ROW_W;
    localparam int RESET_CYCLES = 8;
    localparam int LATENCY      = 3;   // req.valid to rom_valid
    localparam int N_PLAIN      = 40;
    localparam int N_PER_LAYER  = 4;
    localparam int N_OBJALT     = 24;
    localparam int N_SEG        = 16;  // Per CODESEL config segment
    localparam int N_HALF       = 12;  // Per half of an unknown id round
    localparam int TOTAL_REQ    = 1 + N_PLAIN + 5 * N_PER_LAYER + N_OBJALT
                                  + 3 * N_SEG + 6 * N_HALF;
    localparam int MARGIN       = 300; // Writes, idles and drain

    // One expected result tagged with its issue cycle
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              unmapped;
        logic [31:0]       issue;
    } exp_t;

    logic              clk;
    logic              rst;
    logic              cfg_we;
    logic [1:0]        cfg_addr;
    logic [15:0]       cfg_din;
    gfx_req_t          req;
    logic [ADDR_W-1:0] rom_addr;
    logic              rom_valid;
    logic              rom_unmapped;

    exp_t        exp_q[$];       // Outstanding results in issue order
    int          cyc = 0;        // Rising edge count
    int          results_seen = 0;
    logic [15:0] lfsr_state = 16'd95;

    // Shadow of the DUT config registers
    logic [5:0]  sh_game   = 6'd0;
    logic [15:0] sh_offset = 16'h0000;
    logic [15:0] sh_mask   = 16'hffff;

    cps_gfxmap_top #(
        .ROW_W (ROW_W)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_din      (cfg_din),
        .req          (req),
        .rom_addr     (rom_addr),
        .rom_valid    (rom_valid),
        .rom_unmapped (rom_unmapped)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [2:0] random_layer();
        return 3'(rand_bits(4) % 5);  // Objects to stars
    endfunction

    // Expected address and miss flag from the bank and address rules
    function automatic exp_t expected_result(logic [2:0] layer, logic [9:0] code,
                                             logic [3:0] row, logic [5:0] game,
                                             logic [15:0] offset, logic [15:0] mask,
                                             logic [31:0] issue);
        int         bank_idx;  // -1 when no bank is hit
        logic [3:0] off;
        logic [3:0] msk;
        exp_t       e;
        case (game)
            GAME_SPLIT: bank_idx = (layer <= LAYER_SCR3) ? int'(layer) : -1;
            GAME_OBJALT: begin
                if (layer == LAYER_OBJ) bank_idx = code[9] ? 1 : 0;  // Code bit 15
                else bank_idx = 2;
            end
            GAME_CODESEL: bank_idx = (layer == LAYER_STARS) ? -1 : int'(code[9:8]);
            default: bank_idx = 0;  // Plain and unknown ids
        endcase
        if (bank_idx < 0) begin
            off = 4'h0;
            msk = 4'hf;
        end else begin
            off = offset[bank_idx*4 +: 4];
            msk = mask[bank_idx*4 +: 4];
        end
        e.addr     = {layer, off | (code[9:6] & msk), code[5:0], row};
        e.unmapped = (bank_idx < 0);
        e.issue    = issue;
        return e;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic fail_run(string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    // Drives all inputs on one falling edge and updates the shadow config
    task automatic drive_cycle(input logic do_req, input logic [2:0] layer,
                               input logic [9:0] code, input logic [3:0] row,
                               input logic do_wr, input logic [1:0] waddr,
                               input logic [15:0] wdata);
        @(negedge clk);
        req      = '{valid: do_req, layer: layer, code: code, row: row};
        cfg_we   = do_wr;
        cfg_addr = waddr;
        cfg_din  = wdata;
        if (do_req) begin  // Sees the config before this write
            exp_q.push_back(expected_result(layer, code, row, sh_game, sh_offset,
                                            sh_mask, 32'(cyc)));
        end
        if (do_wr) begin
            case (waddr)
                2'd0: sh_game = wdata[5:0];
                2'd1: sh_offset = wdata;
                2'd2: sh_mask = wdata;
                default: ;  // Unused address
            endcase
        end
    endtask

    task automatic idle(int n);
        repeat (n) drive_cycle(1'b0, 3'd0, 10'd0, 4'd0, 1'b0, 2'd0, 16'd0);
    endtask

    task automatic write_cfg(logic [1:0] waddr, logic [15:0] wdata);
        drive_cycle(1'b0, 3'd0, 10'd0, 4'd0, 1'b1, waddr, wdata);
    endtask

    task automatic send_req(logic [2:0] layer, logic [9:0] code);
        drive_cycle(1'b1, layer, code, 4'(rand_bits(4)), 1'b0, 2'd0, 16'd0);
    endtask

    task automatic random_banks();
        write_cfg(2'd1, 16'(rand_bits(16)));
        write_cfg(2'd2, 16'(rand_bits(16)));
    endtask

    // Result checker sampling at the falling edge
    initial begin : result_check
        exp_t e;
        forever begin
            @(negedge clk);
            if (rst) begin
                check_value("rom_valid", 32'(rom_valid), 32'd0);
                check_value("rom_unmapped", 32'(rom_unmapped), 32'd1);
            end else if (rom_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("rom_valid was high with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_value("latency", 32'(cyc) - e.issue, 32'(LATENCY));
                    check_value("rom_addr", 32'(rom_addr), 32'(e.addr));
                    check_value("rom_unmapped", 32'(rom_unmapped), 32'(e.unmapped));
                    results_seen++;
                end
            end else if (results_seen == 0) begin
                check_value("rom_unmapped", 32'(rom_unmapped), 32'd1);  // Reset value held
            end
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + TOTAL_REQ * 4 + MARGIN) @(posedge clk);
        $display("Timeout: the run did not end within the expected number of cycles");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        rst      = 1'b1;
        cfg_we   = 1'b0;
        cfg_addr = 2'd0;
        cfg_din  = 16'd0;
        req      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset config on the first request
        idle(3);
        send_req(random_layer(), 10'(rand_bits(10)));
        idle(4);

        // Back to back under the plain layout
        random_banks();
        for (int i = 0; i < N_PLAIN; i++) send_req(random_layer(), 10'(rand_bits(10)));
        idle(4);

        // One bank per layer with stars unmapped
        write_cfg(2'd0, {10'd0, GAME_SPLIT});
        random_banks();
        for (int l = 0; l < 5; l++) begin
            for (int i = 0; i < N_PER_LAYER; i++) send_req(3'(l), 10'(rand_bits(10)));
        end
        idle(4);

        // Objects split by code bit 15
        write_cfg(2'd0, {10'd0, GAME_OBJALT});
        random_banks();
        for (int i = 0; i < N_OBJALT; i++) begin
            case (i % 3)
                0: send_req(LAYER_OBJ, {1'b0, 9'(rand_bits(9))});
                1: send_req(LAYER_OBJ, {1'b1, 9'(rand_bits(9))});
                default: send_req(3'(1 + rand_bits(2)), 10'(rand_bits(10)));
            endcase
        end
        idle(4);

        // Code selected banks with config rewritten while requests flow
        write_cfg(2'd0, {10'd0, GAME_CODESEL});
        random_banks();
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < N_SEG; i++) begin
                if (i == 5 || i == 6) begin  // Offset then mask in the same cycle as a request
                    drive_cycle(1'b1, random_layer(), 10'(rand_bits(10)), 4'(rand_bits(4)),
                                1'b1, (i == 5) ? 2'd1 : 2'd2, 16'(rand_bits(16)));
                end else begin
                    send_req(random_layer(), 10'(rand_bits(10)));
                end
            end
        end
        idle(4);

        // Unknown ids act as plain and address 3 is ignored
        for (int r = 0; r < 3; r++) begin
            write_cfg(2'd0, {10'(rand_bits(10)), 6'(4 + rand_bits(6) % 60)});
            random_banks();
            for (int i = 0; i < 2 * N_HALF; i++) begin
                if (i == N_HALF) begin
                    drive_cycle(1'b1, random_layer(), 10'(rand_bits(10)), 4'(rand_bits(4)),
                                1'b1, 2'd3, 16'(rand_bits(16)));
                end else begin
                    send_req(random_layer(), 10'(rand_bits(10)));
                end
            end
            idle(2);
        end

        // Drain so late or duplicate results are still caught
        idle(8);
        if (exp_q.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("%0d results never appeared", exp_q.size());
            $display("RESULT: FAIL");
            $fatal(1, "missing results");
        end
    end

endmodule

/* cps_gfxmap.f */
+incdir+hdl
hdl/gfx_pkg.sv
hdl/gfx_map_cfg.sv
hdl/gfx_bank_mapper.sv
hdl/gfx_rom_addr.sv
hdl/cps_gfxmap_top.sv
verification/cps_gfxmap_tb.sv

/* Makefile */
# Verilator simulation of the graphics ROM mapper
# The run's exit status carries pass or fail

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = cps_gfxmap_tb
FILELIST  = cps_gfxmap.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a failing status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
